/* design/reduction_pkg.sv */
/*
  Shared definitions for both offload channels
  Reduction operation codes, channel widths, operand types
*/

`default_nettype none

package reduction_pkg;

  ////////////////////
  // Operations
  ////////////////////

  // Reduction operation as delivered by the router
  typedef logic [1:0] red_op_t;

  localparam red_op_t RED_ADD = 2'd0;
  localparam red_op_t RED_MUL = 2'd1;
  localparam red_op_t RED_MAX = 2'd2;
  localparam red_op_t RED_MIN = 2'd3;

  ////////////////////
  // Widths
  ////////////////////

  // Narrow channel carries 32-bit integers
  localparam int unsigned NARROW_W = 32;

  // Wide channel carries 64-bit integers
  localparam int unsigned WIDE_W = 64;

  ////////////////////
  // Data types
  ////////////////////

  // Operand or result on the narrow channel
  typedef logic [NARROW_W-1:0] narrow_data_t;

  // Operand or result on the wide channel
  typedef logic [WIDE_W-1:0] wide_data_t;

endpackage

`default_nettype wire

/* design/dca_pkg.sv */
/*
  Execution request definitions of the wide channel
  Op codes, mode codes, packed request and response widths
*/

`default_nettype none

package dca_pkg;

  import reduction_pkg::*;

  ////////////////////
  // Op codes
  ////////////////////

  typedef logic [1:0] dca_op_t;

  localparam dca_op_t DCA_ADD    = 2'd0;
  localparam dca_op_t DCA_MUL    = 2'd1;
  localparam dca_op_t DCA_MINMAX = 2'd2;

  // Mode field, picks max or min for MINMAX
  typedef logic dca_rnd_t;

  localparam dca_rnd_t RND_RNE = 1'b0;
  localparam dca_rnd_t RND_RTZ = 1'b1;

  ////////////////////
  // Request layout
  ////////////////////

  // Op, mode, then operand slots 0 to 2 from MSB down
  localparam int unsigned DCA_REQ_W = $bits(dca_op_t) + $bits(dca_rnd_t) + 3 * WIDE_W;

  localparam int unsigned DCA_RESP_W = WIDE_W;

  typedef logic [DCA_REQ_W-1:0] dca_req_t;

endpackage

`default_nettype wire

/* design/spill_register.sv */
/*
  Two-entry elastic buffer
  Registered valid and ready on both sides
*/

`timescale 1ns/1ps
`default_nettype none

module spill_register #(
  parameter int unsigned DATA_W = 32
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              valid_i,
  output logic              ready_o,
  input  logic [DATA_W-1:0] data_i,
  output logic              valid_o,
  input  logic              ready_i,
  output logic [DATA_W-1:0] data_o
);

  typedef enum logic [1:0] {
    FILL_EMPTY,
    FILL_ONE,
    FILL_FULL
  } fill_e;

  fill_e             state_q, state_d;
  logic [DATA_W-1:0] primary_q;
  logic [DATA_W-1:0] spill_q;
  logic              push;
  logic              pop;

  // Both handshake signals come straight from the fill state
  assign ready_o = (state_q != FILL_FULL);
  assign valid_o = (state_q != FILL_EMPTY);
  assign data_o  = primary_q;

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      FILL_EMPTY: begin
        if (push) state_d = FILL_ONE;
      end
      FILL_ONE: begin
        if (push && !pop) state_d = FILL_FULL;
        else if (pop && !push) state_d = FILL_EMPTY;
      end
      FILL_FULL: begin
        if (pop) state_d = FILL_ONE;
      end
      default: state_d = FILL_EMPTY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= FILL_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // Primary is the head; spill only catches a push while the head stalls
  always_ff @(posedge clk_i) begin
    if (pop && (state_q == FILL_FULL)) begin
      primary_q <= spill_q;
    end else if (push && ((state_q == FILL_EMPTY) || pop)) begin
      primary_q <= data_i;
    end
    if (push && !pop && (state_q == FILL_ONE)) begin
      spill_q <= data_i;
    end
  end

endmodule

`default_nettype wire

/* design/wide_request_decoder.sv */
/*
  Wide request decoder
  Reduction op and two operands to a three-slot execution request
*/

`timescale 1ns/1ps
`default_nettype none

module wide_request_decoder
  import reduction_pkg::*;
  import dca_pkg::*;
(
  input  red_op_t    op_i,
  input  wide_data_t op1_i,
  input  wide_data_t op2_i,
  output dca_op_t    dca_op_o,
  output dca_rnd_t   dca_rnd_o,
  output wide_data_t operand0_o,
  output wide_data_t operand1_o,
  output wide_data_t operand2_o
);

  always_comb begin
    // Defaults, unused slots stay zero
    dca_op_o   = DCA_ADD;
    dca_rnd_o  = RND_RNE;
    operand0_o = '0;
    operand1_o = '0;
    operand2_o = '0;

    unique case (op_i)
      RED_ADD: begin
        // Adder reads slots 1 and 2
        dca_op_o   = DCA_ADD;
        operand1_o = op1_i;
        operand2_o = op2_i;
      end
      RED_MUL: begin
        dca_op_o   = DCA_MUL;
        operand0_o = op1_i;
        operand1_o = op2_i;
      end
      RED_MAX: begin
        dca_op_o   = DCA_MINMAX;
        dca_rnd_o  = RND_RNE;
        operand0_o = op1_i;
        operand1_o = op2_i;
      end
      RED_MIN: begin
        dca_op_o   = DCA_MINMAX;
        dca_rnd_o  = RND_RTZ;
        operand0_o = op1_i;
        operand1_o = op2_i;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* design/wide_execution_unit.sv */
/*
  Wide execution unit, two pipeline stages
  Signed 64-bit add, multiply, min and max
*/

`timescale 1ns/1ps
`default_nettype none

module wide_execution_unit
  import reduction_pkg::*;
  import dca_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  dca_op_t    dca_op_i,
  input  dca_rnd_t   dca_rnd_i,
  input  wide_data_t operand0_i,
  input  wide_data_t operand1_i,
  input  wide_data_t operand2_i,
  output logic       resp_valid_o,
  input  logic       resp_ready_i,
  output wide_data_t resp_data_o
);

  logic       s1_valid_q;
  logic       s2_valid_q;
  logic       s1_ready;
  logic       s2_ready;
  dca_op_t    s1_op_q;
  dca_rnd_t   s1_rnd_q;
  wide_data_t s1_opnd0_q;
  wide_data_t s1_opnd1_q;
  wide_data_t s1_opnd2_q;
  wide_data_t result_d;
  wide_data_t s2_result_q;
  logic       opnd0_greater;
  logic       pick_opnd0;

  // A stage moves on when the one ahead is empty or draining
  assign s2_ready    = !s2_valid_q || resp_ready_i;
  assign s1_ready    = !s1_valid_q || s2_ready;
  assign req_ready_o = s1_ready;

  ////////////////////
  // Stage one
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (s1_ready && req_valid_i) begin
      s1_op_q    <= dca_op_i;
      s1_rnd_q   <= dca_rnd_i;
      s1_opnd0_q <= operand0_i;
      s1_opnd1_q <= operand1_i;
      s1_opnd2_q <= operand2_i;
    end
  end

  ////////////////////
  // Stage two
  ////////////////////

  assign opnd0_greater = $signed(s1_opnd0_q) > $signed(s1_opnd1_q);
  // RNE selects max, RTZ selects min
  assign pick_opnd0    = (s1_rnd_q == RND_RNE) ? opnd0_greater : !opnd0_greater;

  always_comb begin
    unique case (s1_op_q)
      DCA_ADD:    result_d = s1_opnd1_q + s1_opnd2_q;
      DCA_MUL:    result_d = s1_opnd0_q * s1_opnd1_q;
      DCA_MINMAX: result_d = pick_opnd0 ? s1_opnd0_q : s1_opnd1_q;
      default:    result_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (s2_ready && s1_valid_q) begin
      s2_result_q <= result_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) s1_valid_q <= req_valid_i;
      if (s2_ready) s2_valid_q <= s1_valid_q;
    end
  end

  assign resp_valid_o = s2_valid_q;
  assign resp_data_o  = s2_result_q;

endmodule

`default_nettype wire

/* design/narrow_reduction_alu.sv */
/*
  Narrow reduction ALU
  Signed 32-bit add, multiply, max, min with a registered result
*/

`timescale 1ns/1ps
`default_nettype none

module narrow_reduction_alu
  import reduction_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         req_valid_i,
  output logic         req_ready_o,
  input  red_op_t      req_op_i,
  input  narrow_data_t op1_i,
  input  narrow_data_t op2_i,
  output logic         resp_valid_o,
  input  logic         resp_ready_i,
  output narrow_data_t resp_data_o
);

  logic         resp_valid_q;
  narrow_data_t resp_data_q;
  narrow_data_t result_d;
  logic         op1_greater;
  logic         accept;

  // One item in flight, a new one enters as the old one leaves
  assign req_ready_o = !resp_valid_q || resp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  assign op1_greater = $signed(op1_i) > $signed(op2_i);

  always_comb begin
    unique case (req_op_i)
      RED_ADD: result_d = op1_i + op2_i;
      RED_MUL: result_d = op1_i * op2_i;
      RED_MAX: result_d = op1_greater ? op1_i : op2_i;
      RED_MIN: result_d = op1_greater ? op2_i : op1_i;
      default: result_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  // Result holds until taken
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_data_q <= result_d;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_data_o  = resp_data_q;

endmodule

`default_nettype wire

/* design/offload_reduction_top.sv */
/*
  Reduction offload datapath of the cluster tile
  Narrow channel: integer ALU
  Wide channel: decoder, request cut, execution unit, response cut
*/

`timescale 1ns/1ps
`default_nettype none

module offload_reduction_top
  import reduction_pkg::*;
  import dca_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  // Narrow channel
  input  logic         narrow_req_valid_i,
  output logic         narrow_req_ready_o,
  input  red_op_t      narrow_req_op_i,
  input  narrow_data_t narrow_op1_i,
  input  narrow_data_t narrow_op2_i,
  output logic         narrow_resp_valid_o,
  output narrow_data_t narrow_resp_data_o,
  input  logic         narrow_resp_ready_i,
  // Wide channel
  input  logic         wide_req_valid_i,
  output logic         wide_req_ready_o,
  input  red_op_t      wide_req_op_i,
  input  wide_data_t   wide_op1_i,
  input  wide_data_t   wide_op2_i,
  output logic         wide_resp_valid_o,
  output wide_data_t   wide_resp_data_o,
  input  logic         wide_resp_ready_i
);

  ////////////////////
  // Narrow channel
  ////////////////////

  narrow_reduction_alu i_narrow_alu (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (narrow_req_valid_i),
    .req_ready_o  (narrow_req_ready_o),
    .req_op_i     (narrow_req_op_i),
    .op1_i        (narrow_op1_i),
    .op2_i        (narrow_op2_i),
    .resp_valid_o (narrow_resp_valid_o),
    .resp_ready_i (narrow_resp_ready_i),
    .resp_data_o  (narrow_resp_data_o)
  );

  ////////////////////
  // Wide channel
  ////////////////////

  dca_op_t    dec_op;
  dca_rnd_t   dec_rnd;
  wide_data_t dec_opnd0;
  wide_data_t dec_opnd1;
  wide_data_t dec_opnd2;
  dca_req_t   dca_req_data;
  logic       dca_req_valid_q;
  logic       dca_req_ready_q;
  dca_req_t   dca_req_data_q;
  dca_op_t    exe_op;
  dca_rnd_t   exe_rnd;
  wide_data_t exe_opnd0;
  wide_data_t exe_opnd1;
  wide_data_t exe_opnd2;
  logic       dca_resp_valid;
  logic       dca_resp_ready;
  wide_data_t dca_resp_data;

  wide_request_decoder i_wide_decoder (
    .op_i       (wide_req_op_i),
    .op1_i      (wide_op1_i),
    .op2_i      (wide_op2_i),
    .dca_op_o   (dec_op),
    .dca_rnd_o  (dec_rnd),
    .operand0_o (dec_opnd0),
    .operand1_o (dec_opnd1),
    .operand2_o (dec_opnd2)
  );

  assign dca_req_data = {dec_op, dec_rnd, dec_opnd0, dec_opnd1, dec_opnd2};

  // Request cut
  spill_register #(
    .DATA_W (DCA_REQ_W)
  ) i_cut_dca_req (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (wide_req_valid_i),
    .ready_o (wide_req_ready_o),
    .data_i  (dca_req_data),
    .valid_o (dca_req_valid_q),
    .ready_i (dca_req_ready_q),
    .data_o  (dca_req_data_q)
  );

  assign {exe_op, exe_rnd, exe_opnd0, exe_opnd1, exe_opnd2} = dca_req_data_q;

  wide_execution_unit i_wide_exec (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (dca_req_valid_q),
    .req_ready_o  (dca_req_ready_q),
    .dca_op_i     (exe_op),
    .dca_rnd_i    (exe_rnd),
    .operand0_i   (exe_opnd0),
    .operand1_i   (exe_opnd1),
    .operand2_i   (exe_opnd2),
    .resp_valid_o (dca_resp_valid),
    .resp_ready_i (dca_resp_ready),
    .resp_data_o  (dca_resp_data)
  );

  // Response cut
  spill_register #(
    .DATA_W (DCA_RESP_W)
  ) i_cut_dca_resp (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (dca_resp_valid),
    .ready_o (dca_resp_ready),
    .data_i  (dca_resp_data),
    .valid_o (wide_resp_valid_o),
    .ready_i (wide_resp_ready_i),
    .data_o  (wide_resp_data_o)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
/*
  Testbench clock source, 20 ns period
*/

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned HALF_PERIOD_NS = 10
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

/* testbench/tb_offload_reduction.sv */
/*
  Testbench of the reduction offload datapath
  Directed tests on both channels, reference model, checker, timeout
*/

`timescale 1ns/1ps
`default_nettype none

module tb_offload_reduction
  import reduction_pkg::*;
();

  // Limit well above the length of all tests together
  localparam int unsigned MAX_CYCLES = 2000;
  localparam int unsigned STREAM_LEN = 20;
  localparam logic [63:0] SEED       = 64'd41;

  logic         clk;
  logic         rst_n;
  logic         narrow_req_valid;
  logic         narrow_req_ready;
  red_op_t      narrow_req_op;
  narrow_data_t narrow_op1;
  narrow_data_t narrow_op2;
  logic         narrow_resp_valid;
  narrow_data_t narrow_resp_data;
  logic         narrow_resp_ready;
  logic         wide_req_valid;
  logic         wide_req_ready;
  red_op_t      wide_req_op;
  wide_data_t   wide_op1;
  wide_data_t   wide_op2;
  logic         wide_resp_valid;
  wide_data_t   wide_resp_data;
  logic         wide_resp_ready;

  int           error_count = 0;
  int           cycle_count = 0;
  logic [63:0]  rng_state;
  logic [63:0]  expected_q[$];

  tb_clock_gen i_clock_gen (
    .clk_o (clk)
  );

  offload_reduction_top dut_i (
    .clk_i               (clk),
    .rst_n_i             (rst_n),
    .narrow_req_valid_i  (narrow_req_valid),
    .narrow_req_ready_o  (narrow_req_ready),
    .narrow_req_op_i     (narrow_req_op),
    .narrow_op1_i        (narrow_op1),
    .narrow_op2_i        (narrow_op2),
    .narrow_resp_valid_o (narrow_resp_valid),
    .narrow_resp_data_o  (narrow_resp_data),
    .narrow_resp_ready_i (narrow_resp_ready),
    .wide_req_valid_i    (wide_req_valid),
    .wide_req_ready_o    (wide_req_ready),
    .wide_req_op_i       (wide_req_op),
    .wide_op1_i          (wide_op1),
    .wide_op2_i          (wide_op2),
    .wide_resp_valid_o   (wide_resp_valid),
    .wide_resp_data_o    (wide_resp_data),
    .wide_resp_ready_i   (wide_resp_ready)
  );

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [63:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  // Signed reduction on 64-bit values
  function automatic logic [63:0] ref_result(input red_op_t op, input logic signed [63:0] a,
                                             input logic signed [63:0] b);
    case (op)
      RED_ADD: return a + b;
      RED_MUL: return a * b;
      RED_MAX: return (a > b) ? a : b;
      default: return (a < b) ? a : b;
    endcase
  endfunction

  // 32-bit result from sign-extended operands
  function automatic narrow_data_t narrow_ref(input red_op_t op, input narrow_data_t a,
                                              input narrow_data_t b);
    logic [63:0] full;
    full = ref_result(op, {{32{a[31]}}, a}, {{32{b[31]}}, b});
    return full[31:0];
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t: %s", $time, what);
    error_count++;
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_narrow(input red_op_t op, input narrow_data_t a, input narrow_data_t b);
    narrow_req_valid = 1'b1;
    narrow_req_op    = op;
    narrow_op1       = a;
    narrow_op2       = b;
  endtask

  task automatic drive_wide(input red_op_t op, input wide_data_t a, input wide_data_t b);
    wide_req_valid = 1'b1;
    wide_req_op    = op;
    wide_op1       = a;
    wide_op2       = b;
  endtask

  task automatic drive_wide_random();
    logic [63:0] r;
    r = next_random();
    drive_wide(r[1:0], next_random(), next_random());
  endtask

  // Takes count wide results in order, then expects the channel idle
  task automatic collect_wide(input int count);
    int received;
    received = 0;
    while (received < count) begin
      @(negedge clk);
      if (wide_resp_valid) begin
        if (expected_q.size() == 0) begin
          report_failure("Wide response arrived with no request outstanding");
        end else begin
          check_value("wide_resp_data_o", expected_q.pop_front(), wide_resp_data);
        end
        received++;
      end
    end
    @(negedge clk);
    check_value("wide_resp_valid_o", 0, wide_resp_valid);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic check_reset_state();
    @(negedge clk);
    check_value("narrow_resp_valid_o", 0, narrow_resp_valid);
    check_value("wide_resp_valid_o", 0, wide_resp_valid);
    check_value("narrow_req_ready_o", 1, narrow_req_ready);
    check_value("wide_req_ready_o", 1, wide_req_ready);
    next_cycle();
  endtask

  // One request, then latency in edges from acceptance to response transfer
  task automatic run_single_op(input bit is_wide, input red_op_t op,
                               input logic [63:0] a, input logic [63:0] b);
    logic [63:0] expected;
    logic [63:0] actual;
    int          latency;
    string       tag;
    tag = is_wide ? "wide" : "narrow";
    if (is_wide) begin
      expected = ref_result(op, a, b);
      drive_wide(op, a, b);
    end else begin
      expected = {32'b0, narrow_ref(op, a[31:0], b[31:0])};
      drive_narrow(op, a[31:0], b[31:0]);
    end
    @(negedge clk);
    while (!(is_wide ? wide_req_ready : narrow_req_ready)) @(negedge clk);
    next_cycle();
    wide_req_valid   = 1'b0;
    narrow_req_valid = 1'b0;
    latency = 1;
    @(negedge clk);
    while (!(is_wide ? wide_resp_valid : narrow_resp_valid)) begin
      latency++;
      @(negedge clk);
    end
    actual = is_wide ? wide_resp_data : {32'b0, narrow_resp_data};
    check_value({tag, "_resp_data_o"}, expected, actual);
    check_value({tag, " response latency"}, is_wide ? 4 : 1, latency);
    next_cycle();
  endtask

  task automatic run_wide_stream();
    int sent;
    fork
      begin
        for (sent = 0; sent < STREAM_LEN; sent++) begin
          drive_wide_random();
          @(negedge clk);
          while (!wide_req_ready) @(negedge clk);
          expected_q.push_back(ref_result(wide_req_op, wide_op1, wide_op2));
          next_cycle();
        end
        wide_req_valid = 1'b0;
      end
      collect_wide(STREAM_LEN);
    join
    next_cycle();
  endtask

  task automatic run_wide_backpressure();
    int accepted;
    wide_resp_ready = 1'b0;
    accepted = 0;
    drive_wide_random();
    @(negedge clk);
    while (wide_req_ready && accepted < 7) begin
      expected_q.push_back(ref_result(wide_req_op, wide_op1, wide_op2));
      accepted++;
      next_cycle();
      drive_wide_random();
      @(negedge clk);
    end
    if (accepted < 1 || accepted > 6) begin
      report_failure($sformatf("Wide channel accepted %0d requests under back-pressure",
                               accepted));
    end
    check_value("wide_resp_valid_o", 1, wide_resp_valid);
    next_cycle();
    wide_resp_ready = 1'b1;
    // The stalled request is still pending and goes in after release
    fork
      begin
        @(negedge clk);
        while (!wide_req_ready) @(negedge clk);
        expected_q.push_back(ref_result(wide_req_op, wide_op1, wide_op2));
        next_cycle();
        wide_req_valid = 1'b0;
      end
      collect_wide(accepted + 1);
    join
    next_cycle();
  endtask

  task automatic run_narrow_backpressure();
    narrow_data_t first;
    narrow_data_t second;
    first  = narrow_ref(RED_MUL, -32'sd3, 32'sd9);
    second = narrow_ref(RED_MAX, -32'sd8, -32'sd2);
    narrow_resp_ready = 1'b0;
    drive_narrow(RED_MUL, -32'sd3, 32'sd9);
    @(negedge clk);
    while (!narrow_req_ready) @(negedge clk);
    next_cycle();
    drive_narrow(RED_MAX, -32'sd8, -32'sd2);
    repeat (2) begin
      @(negedge clk);
      check_value("narrow_req_ready_o", 0, narrow_req_ready);
      check_value("narrow_resp_valid_o", 1, narrow_resp_valid);
      check_value("narrow_resp_data_o", first, narrow_resp_data);
      next_cycle();
    end
    narrow_resp_ready = 1'b1;
    // Held result leaves on the same edge the second request enters
    @(negedge clk);
    check_value("narrow_req_ready_o", 1, narrow_req_ready);
    check_value("narrow_resp_data_o", first, narrow_resp_data);
    next_cycle();
    narrow_req_valid = 1'b0;
    @(negedge clk);
    check_value("narrow_resp_valid_o", 1, narrow_resp_valid);
    check_value("narrow_resp_data_o", second, narrow_resp_data);
    next_cycle();
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout reached after %0d cycles", cycle_count);
      $display("Errors: %0d", error_count);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    rng_state         = SEED;
    rst_n             = 1'b0;
    narrow_req_valid  = 1'b0;
    narrow_req_op     = RED_ADD;
    narrow_op1        = '0;
    narrow_op2        = '0;
    narrow_resp_ready = 1'b1;
    wide_req_valid    = 1'b0;
    wide_req_op       = RED_ADD;
    wide_op1          = '0;
    wide_op2          = '0;
    wide_resp_ready   = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    check_reset_state();
    run_single_op(1'b0, RED_ADD, -64'sd10, 64'sd3);
    run_single_op(1'b0, RED_MUL, 64'h0001_0000, 64'h0003_0001);
    run_single_op(1'b0, RED_MAX, -64'sd20, 64'sd5);
    run_single_op(1'b0, RED_MIN, -64'sd20, 64'sd5);
    run_single_op(1'b1, RED_ADD, -64'sd123456789012, 64'sd98765);
    run_single_op(1'b1, RED_MUL, 64'h0000_0001_0000_0003, -64'sd7);
    run_single_op(1'b1, RED_MAX, -64'sd1, 64'sd42);
    run_single_op(1'b1, RED_MIN, 64'sh7fff_0000_0000_0000, -64'sd5);
    run_wide_stream();
    run_wide_backpressure();
    run_narrow_backpressure();

    $display("Errors: %0d", error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
design/reduction_pkg.sv
design/dca_pkg.sv
design/spill_register.sv
design/wide_request_decoder.sv
design/wide_execution_unit.sv
design/narrow_reduction_alu.sv
design/offload_reduction_top.sv
testbench/tb_clock_gen.sv
testbench/tb_offload_reduction.sv
